//--- hw/ipod_audio_pkg.sv
`default_nettype none

package ipod_audio_pkg;

  // ==============================
  // Flash word geometry
  // ==============================

  // One flash word carries two samples
  localparam int WORD_W = 32;
  localparam int SAMPLE_W = 16;

  // Word address into the flash
  localparam int ADDR_W = 23;

  // ==============================
  // Song and buffer sizing
  // ==============================

  // Whole song area, in words
  localparam int SONG_WORDS_DEFAULT = 524288;

  // Words held between the reader and the player
  localparam int FIFO_DEPTH_DEFAULT = 8;

endpackage

`default_nettype wire

//--- hw/ipod_control_pkg.sv
`default_nettype none

package ipod_control_pkg;

  // ==============================
  // Keyboard commands, ASCII
  // ==============================
  localparam logic [7:0] CMD_PLAY = 8'h45;      // 'E'
  localparam logic [7:0] CMD_PAUSE = 8'h44;     // 'D'
  localparam logic [7:0] CMD_FORWARD = 8'h46;   // 'F'
  localparam logic [7:0] CMD_BACKWARD = 8'h42;  // 'B'
  localparam logic [7:0] CMD_RESTART = 8'h52;   // 'R'

  // ==============================
  // Sample rate divisor
  // ==============================
  localparam int DIV_W = 16;

  // 50 MHz / 2272 gives about 22 kHz
  localparam logic [DIV_W-1:0] DIVISOR_DEFAULT = 16'd2272;
  localparam logic [DIV_W-1:0] DIVISOR_STEP = 16'd64;
  localparam logic [DIV_W-1:0] DIVISOR_MIN = 16'd1136;
  localparam logic [DIV_W-1:0] DIVISOR_MAX = 16'd4544;

  // Held key repeats ten times a second
  localparam int REPEAT_CYCLES_DEFAULT = 5000000;

endpackage

`default_nettype wire

//--- hw/player_control.sv
`default_nettype none
`timescale 1ns/1ps

module player_control #(
  parameter int REPEAT_CYCLES = ipod_control_pkg::REPEAT_CYCLES_DEFAULT
) (
  input  logic                                 CLK_50M,
  input  logic                                 reset,
  input  logic [7:0]                           kbd_ascii,
  input  logic                                 kbd_valid,
  input  logic                                 speed_up,
  input  logic                                 speed_down,
  input  logic                                 speed_reset,
  output logic                                 playing,
  output logic                                 forward,
  output logic                                 flush,
  output logic [ipod_control_pkg::DIV_W-1:0]   divisor
);

  localparam int RPT_W = $clog2(REPEAT_CYCLES + 1);
  localparam int RPT_LAST = REPEAT_CYCLES - 1;
  localparam logic [RPT_W-1:0] RPT_WRAP = RPT_LAST[RPT_W-1:0];

  logic             up_q;
  logic             down_q;
  logic [RPT_W-1:0] rpt_cnt;
  logic             rpt_due;
  logic             key_held;
  logic             key_edge;
  logic             step_faster;
  logic             step_slower;
  logic [ipod_control_pkg::DIV_W-1:0] div_faster;
  logic [ipod_control_pkg::DIV_W-1:0] div_slower;

  // ==============================
  // Keyboard commands
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      playing <= 1'b0;
      forward <= 1'b1;
      flush   <= 1'b0;
    end
    else
    begin
      flush <= 1'b0;
      if (kbd_valid)
      begin
        case (kbd_ascii)
          ipod_control_pkg::CMD_PLAY:    playing <= 1'b1;
          ipod_control_pkg::CMD_PAUSE:   playing <= 1'b0;
          ipod_control_pkg::CMD_RESTART: flush <= 1'b1;
          ipod_control_pkg::CMD_FORWARD:
          begin
            // Flush only on a real turn
            if (!forward)
            begin
              forward <= 1'b1;
              flush   <= 1'b1;
            end
          end
          ipod_control_pkg::CMD_BACKWARD:
          begin
            if (forward)
            begin
              forward <= 1'b0;
              flush   <= 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // ==============================
  // Speed keys
  // ==============================
  assign key_held = speed_up || speed_down;
  assign key_edge = (speed_up && !up_q) || (speed_down && !down_q);
  assign rpt_due = (rpt_cnt == RPT_WRAP);

  // Up wins when both keys are down
  assign step_faster = speed_up && (!up_q || rpt_due);
  assign step_slower = !speed_up && speed_down && (!down_q || rpt_due);

  // Clamped neighbours of the current divisor
  assign div_faster = (divisor < ipod_control_pkg::DIVISOR_MIN + ipod_control_pkg::DIVISOR_STEP)
                      ? ipod_control_pkg::DIVISOR_MIN
                      : divisor - ipod_control_pkg::DIVISOR_STEP;
  assign div_slower = (divisor > ipod_control_pkg::DIVISOR_MAX - ipod_control_pkg::DIVISOR_STEP)
                      ? ipod_control_pkg::DIVISOR_MAX
                      : divisor + ipod_control_pkg::DIVISOR_STEP;

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      up_q    <= 1'b0;
      down_q  <= 1'b0;
      rpt_cnt <= '0;
      divisor <= ipod_control_pkg::DIVISOR_DEFAULT;
    end
    else
    begin
      up_q   <= speed_up;
      down_q <= speed_down;

      // Repeat interval restarts on each press and each step
      if (!key_held || key_edge || rpt_due)
        rpt_cnt <= '0;
      else
        rpt_cnt <= rpt_cnt + 1'b1;

      if (speed_reset)
        divisor <= ipod_control_pkg::DIVISOR_DEFAULT;
      else if (step_faster)
        divisor <= div_faster;
      else if (step_slower)
        divisor <= div_slower;
    end
  end

endmodule

`default_nettype wire

//--- hw/sample_tick_gen.sv
`default_nettype none
`timescale 1ns/1ps

module sample_tick_gen (
  input  logic                               CLK_50M,
  input  logic                               reset,
  input  logic [ipod_control_pkg::DIV_W-1:0] divisor,
  output logic                               tick
);

  logic [ipod_control_pkg::DIV_W-1:0] count;
  logic [ipod_control_pkg::DIV_W-1:0] count_last;

  assign count_last = divisor - 1'b1;

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      count <= '0;
      tick  <= 1'b0;
    end
    else if (count > count_last)
    begin
      // Divisor shrank under the count, start over
      count <= '0;
      tick  <= 1'b0;
    end
    else if (count == count_last)
    begin
      count <= '0;
      tick  <= 1'b1;
    end
    else
    begin
      count <= count + 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hw/flash_reader.sv
`default_nettype none
`timescale 1ns/1ps

module flash_reader #(
  parameter int SONG_WORDS = ipod_audio_pkg::SONG_WORDS_DEFAULT
) (
  input  logic                                CLK_50M,
  input  logic                                reset,
  input  logic                                forward,
  input  logic                                flush,
  input  logic                                full,
  output logic                                wb_cyc,
  output logic                                wb_stb,
  output logic [ipod_audio_pkg::ADDR_W-1:0]   wb_adr,
  input  logic                                wb_ack,
  input  logic [ipod_audio_pkg::WORD_W-1:0]   wb_dat,
  output logic                                push,
  output logic [ipod_audio_pkg::WORD_W-1:0]   push_word
);

  localparam int AW = ipod_audio_pkg::ADDR_W;
  localparam int SONG_LAST = SONG_WORDS - 1;
  localparam logic [AW-1:0] LAST_ADR = SONG_LAST[AW-1:0];

  logic [AW-1:0] next_adr;
  logic          fwd_q;
  logic          discard;

  // Neighbour address, wrapping at both ends of the song
  function automatic logic [AW-1:0] step_adr(input logic [AW-1:0] adr, input logic fwd);
    if (fwd)
      return (adr == LAST_ADR) ? '0 : adr + 1'b1;
    else
      return (adr == '0) ? LAST_ADR : adr - 1'b1;
  endfunction

  // Classic cycle, strobe follows cycle
  assign wb_stb = wb_cyc;

  // Word goes straight into the buffer on ack unless stale
  assign push = wb_cyc && wb_ack && !discard && !flush;
  assign push_word = wb_dat;

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      wb_cyc   <= 1'b0;
      wb_adr   <= '0;
      next_adr <= '0;
      fwd_q    <= 1'b1;
      discard  <= 1'b0;
    end
    else
    begin
      fwd_q <= forward;

      if (wb_cyc)
      begin
        if (wb_ack)
        begin
          wb_cyc  <= 1'b0;
          discard <= 1'b0;
        end
        else if (flush)
          discard <= 1'b1;
      end
      else if (!full && !flush)
      begin
        wb_cyc   <= 1'b1;
        wb_adr   <= next_adr;
        next_adr <= step_adr(next_adr, forward);
      end

      // wb_adr still holds the last address fetched
      if (flush)
      begin
        if (forward != fwd_q)
          next_adr <= step_adr(wb_adr, forward);
        else
          next_adr <= forward ? '0 : LAST_ADR;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/sample_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module sample_fifo #(
  parameter int FIFO_DEPTH = ipod_audio_pkg::FIFO_DEPTH_DEFAULT
) (
  input  logic                              CLK_50M,
  input  logic                              reset,
  input  logic                              flush,
  input  logic                              push,
  input  logic [ipod_audio_pkg::WORD_W-1:0] push_word,
  input  logic                              pop,
  output logic                              full,
  output logic                              empty,
  output logic [ipod_audio_pkg::WORD_W-1:0] head_word
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int PTR_LAST = FIFO_DEPTH - 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_LAST[PTR_W-1:0];
  localparam logic [PTR_W:0] DEPTH_CNT = FIFO_DEPTH[PTR_W:0];

  logic [ipod_audio_pkg::WORD_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  assign full = (count == DEPTH_CNT);
  assign empty = (count == '0);
  assign head_word = mem[rd_ptr];

  assign do_push = push && !full && !flush;
  assign do_pop = pop && !empty && !flush;

  always_ff @(posedge CLK_50M)
  begin
    if (do_push)
      mem[wr_ptr] <= push_word;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset || flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/sample_player.sv
`default_nettype none
`timescale 1ns/1ps

module sample_player (
  input  logic                                CLK_50M,
  input  logic                                reset,
  input  logic                                tick,
  input  logic                                playing,
  input  logic                                forward,
  input  logic                                flush,
  input  logic                                empty,
  input  logic [ipod_audio_pkg::WORD_W-1:0]   head_word,
  output logic                                pop,
  output logic [ipod_audio_pkg::SAMPLE_W-1:0] sample,
  output logic                                sample_valid
);

  localparam int SW = ipod_audio_pkg::SAMPLE_W;

  logic [ipod_audio_pkg::WORD_W-1:0] held_word;
  logic held_valid;
  logic half;
  logic emit;
  logic take_high;

  // Refill as soon as the held word is spent
  assign pop = !held_valid && !empty && !flush;
  assign emit = tick && playing && held_valid && !flush;

  // Forward plays low then high, backward the reverse
  assign take_high = half ^ !forward;

  always_ff @(posedge CLK_50M)
  begin
    if (reset || flush)
    begin
      held_valid   <= 1'b0;
      half         <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= emit;
      if (pop)
      begin
        held_valid <= 1'b1;
        half       <= 1'b0;
      end
      else if (emit)
      begin
        if (half)
          held_valid <= 1'b0;
        half <= !half;
      end
    end
  end

  // Payload path
  always_ff @(posedge CLK_50M)
  begin
    if (pop)
      held_word <= head_word;
    if (emit)
      sample <= take_high ? held_word[2*SW-1:SW] : held_word[SW-1:0];
  end

endmodule

`default_nettype wire

//--- hw/ipod_top.sv
`default_nettype none
`timescale 1ns/1ps

module ipod_top #(
  parameter int SONG_WORDS = ipod_audio_pkg::SONG_WORDS_DEFAULT,
  parameter int FIFO_DEPTH = ipod_audio_pkg::FIFO_DEPTH_DEFAULT,
  parameter int REPEAT_CYCLES = ipod_control_pkg::REPEAT_CYCLES_DEFAULT
) (
  input  logic                                 CLK_50M,
  input  logic                                 reset,
  input  logic [7:0]                           kbd_ascii,
  input  logic                                 kbd_valid,
  input  logic                                 speed_up,
  input  logic                                 speed_down,
  input  logic                                 speed_reset,
  output logic                                 wb_cyc,
  output logic                                 wb_stb,
  output logic [ipod_audio_pkg::ADDR_W-1:0]    wb_adr,
  input  logic                                 wb_ack,
  input  logic [ipod_audio_pkg::WORD_W-1:0]    wb_dat,
  output logic [ipod_audio_pkg::SAMPLE_W-1:0]  sample,
  output logic                                 sample_valid,
  output logic [ipod_control_pkg::DIV_W-1:0]   divisor
);

  logic playing;
  logic forward;
  logic flush;
  logic tick;
  logic full;
  logic empty;
  logic push;
  logic pop;
  logic [ipod_audio_pkg::WORD_W-1:0] push_word;
  logic [ipod_audio_pkg::WORD_W-1:0] head_word;

  // ==============================
  // Control and sample rate
  // ==============================
  player_control #(
    .REPEAT_CYCLES (REPEAT_CYCLES)
  ) u_player_control (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .kbd_ascii   (kbd_ascii),
    .kbd_valid   (kbd_valid),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .playing     (playing),
    .forward     (forward),
    .flush       (flush),
    .divisor     (divisor)
  );

  sample_tick_gen u_sample_tick_gen (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .divisor (divisor),
    .tick    (tick)
  );

  // ==============================
  // Flash to audio datapath
  // ==============================
  flash_reader #(
    .SONG_WORDS (SONG_WORDS)
  ) u_flash_reader (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .forward   (forward),
    .flush     (flush),
    .full      (full),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_adr    (wb_adr),
    .wb_ack    (wb_ack),
    .wb_dat    (wb_dat),
    .push      (push),
    .push_word (push_word)
  );

  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_sample_fifo (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .flush     (flush),
    .push      (push),
    .push_word (push_word),
    .pop       (pop),
    .full      (full),
    .empty     (empty),
    .head_word (head_word)
  );

  sample_player u_sample_player (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .tick         (tick),
    .playing      (playing),
    .forward      (forward),
    .flush        (flush),
    .empty        (empty),
    .head_word    (head_word),
    .pop          (pop),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

endmodule

`default_nettype wire

//--- test/ipod_properties.sv
`default_nettype none
`timescale 1ns/1ps

module ipod_properties (
  input logic                              CLK_50M,
  input logic                              reset,
  input logic                              wb_cyc,
  input logic                              wb_stb,
  input logic [ipod_audio_pkg::ADDR_W-1:0] wb_adr,
  input logic                              wb_ack,
  input logic                              push,
  input logic                              full,
  input logic                              pop,
  input logic                              empty
);

  // ==============================
  // Wishbone classic read
  // ==============================
  stb_in_cycle: assert property (@(posedge CLK_50M) disable iff (reset)
    wb_stb |-> wb_cyc)
    else $error("wb_stb high outside a bus cycle");

  // Address and cycle held until the slave acks
  adr_held: assert property (@(posedge CLK_50M) disable iff (reset)
    wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_adr))
    else $error("wb_adr or wb_cyc changed before wb_ack");

  // ==============================
  // Buffer handshakes
  // ==============================
  no_push_full: assert property (@(posedge CLK_50M) disable iff (reset)
    !(push && full))
    else $error("push while the buffer is full");

  no_pop_empty: assert property (@(posedge CLK_50M) disable iff (reset)
    !(pop && empty))
    else $error("pop while the buffer is empty");

endmodule

// Reader instance watches the bus, buffer instance watches both buffer ports
bind flash_reader ipod_properties u_reader_props (
  .CLK_50M (CLK_50M),
  .reset   (reset),
  .wb_cyc  (wb_cyc),
  .wb_stb  (wb_stb),
  .wb_adr  (wb_adr),
  .wb_ack  (wb_ack),
  .push    (push),
  .full    (full),
  .pop     (1'b0),
  .empty   (1'b0)
);

bind sample_fifo ipod_properties u_fifo_props (
  .CLK_50M (CLK_50M),
  .reset   (reset),
  .wb_cyc  (1'b0),
  .wb_stb  (1'b0),
  .wb_adr  ('0),
  .wb_ack  (1'b0),
  .push    (push),
  .full    (full),
  .pop     (pop),
  .empty   (empty)
);

`default_nettype wire

//--- test/ipod_tb.sv
`default_nettype none
`timescale 1ns/1ps

module ipod_tb;

  localparam int SONG_WORDS = 16;
  localparam int FIFO_DEPTH = 4;
  localparam int REPEAT_CYCLES = 8;
  localparam int SW = ipod_audio_pkg::SAMPLE_W;
  localparam int DW = ipod_control_pkg::DIV_W;
  localparam int AW = ipod_audio_pkg::ADDR_W;
  localparam int SAMPLE_COUNT = 2 * SONG_WORDS;
  localparam int LAST_INDEX = SAMPLE_COUNT - 1;

  // Playback lengths in samples or ticks
  localparam int FWD_SAMPLES = 40;
  localparam int BWD_SAMPLES = 40;
  localparam int SHORT_SAMPLES = 6;
  localparam int PAUSE_TICKS = 4;
  localparam int TOTAL_TICKS = FWD_SAMPLES + BWD_SAMPLES + 4 * SHORT_SAMPLES + PAUSE_TICKS;
  localparam int WATCHDOG_CYCLES = TOTAL_TICKS * int'(ipod_control_pkg::DIVISOR_MAX) + 20000;

  logic          CLK_50M = 1'b0;
  logic          reset;
  logic [7:0]    kbd_ascii;
  logic          kbd_valid;
  logic          speed_up;
  logic          speed_down;
  logic          speed_reset;
  logic          wb_cyc;
  logic          wb_stb;
  logic [AW-1:0] wb_adr;
  logic          wb_ack = 1'b0;
  logic [31:0]   wb_dat = '0;
  logic [SW-1:0] sample;
  logic          sample_valid;
  logic [DW-1:0] divisor;

  // Flash model state
  int  stall_left = 0;
  bit  stall_busy = 1'b0;
  int  seed_value;

  // Expectations set by the stimulus and read by the checker
  bit            quiet = 1'b1;
  bit            dir_fwd = 1'b1;
  int            cmd_gen = 0;
  bit            resync_exact = 1'b0;
  logic [SW-1:0] resync_val = '0;
  logic [DW-1:0] exp_div;

  // Checker state
  int            seen_gen = 0;
  int            sample_count = 0;
  int            fwd_wraps = 0;
  int            bwd_wraps = 0;
  logic [SW-1:0] prev_sample = '0;
  logic [SW-1:0] expected_sample;

  int sample_errors = 0;
  int quiet_errors = 0;
  int divisor_errors = 0;
  int wrap_errors = 0;

  always #10 CLK_50M = ~CLK_50M;

  ipod_top #(
    .SONG_WORDS    (SONG_WORDS),
    .FIFO_DEPTH    (FIFO_DEPTH),
    .REPEAT_CYCLES (REPEAT_CYCLES)
  ) UUT (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .kbd_ascii    (kbd_ascii),
    .kbd_valid    (kbd_valid),
    .speed_up     (speed_up),
    .speed_down   (speed_down),
    .speed_reset  (speed_reset),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_adr       (wb_adr),
    .wb_ack       (wb_ack),
    .wb_dat       (wb_dat),
    .sample       (sample),
    .sample_valid (sample_valid),
    .divisor      (divisor)
  );

  // ==============================
  // Reference model
  // ==============================

  // Word a holds sample 2a low and 2a+1 high
  function automatic logic [31:0] word_at(input logic [AW-1:0] adr);
    int a;
    a = int'(adr);
    return {16'(2 * a + 1), 16'(2 * a)};
  endfunction

  function automatic logic [SW-1:0] next_sample(input logic [SW-1:0] prev, input bit fwd);
    int n;
    n = int'(prev);
    if (fwd)
      n = (n + 1) % SAMPLE_COUNT;
    else
      n = (n + SAMPLE_COUNT - 1) % SAMPLE_COUNT;
    return n[SW-1:0];
  endfunction

  // One step on the press edge, then one per full repeat interval
  function automatic int steps_for_hold(input int cycles);
    return 1 + (cycles - 1) / REPEAT_CYCLES;
  endfunction

  function automatic logic [DW-1:0] stepped_divisor(input logic [DW-1:0] start,
                                                    input int steps, input bit faster);
    int d;
    d = int'(start);
    for (int i = 0; i < steps; i++)
    begin
      if (faster)
        d = d - int'(ipod_control_pkg::DIVISOR_STEP);
      else
        d = d + int'(ipod_control_pkg::DIVISOR_STEP);
      if (d < int'(ipod_control_pkg::DIVISOR_MIN))
        d = int'(ipod_control_pkg::DIVISOR_MIN);
      if (d > int'(ipod_control_pkg::DIVISOR_MAX))
        d = int'(ipod_control_pkg::DIVISOR_MAX);
    end
    return d[DW-1:0];
  endfunction

  // ==============================
  // Flash memory as Wishbone slave
  // ==============================
  initial seed_value = $urandom(32'hb1e9_7aec);

  always @(negedge CLK_50M)
  begin
    if (reset)
    begin
      wb_ack = 1'b0;
      stall_busy = 1'b0;
    end
    else if (wb_ack)
      wb_ack = 1'b0;
    else if (wb_cyc && wb_stb)
    begin
      if (!stall_busy)
      begin
        stall_left = int'($urandom % 4);
        stall_busy = 1'b1;
      end
      if (stall_left == 0)
      begin
        wb_dat = word_at(wb_adr);
        wb_ack = 1'b1;
        stall_busy = 1'b0;
      end
      else
        stall_left--;
    end
  end

  // ==============================
  // Sample checker
  // ==============================
  always @(negedge CLK_50M)
  begin
    if (sample_valid === 1'b1)
    begin
      assert (!quiet) else
      begin
        quiet_errors++;
        $display("sample_valid pulsed while playback was stopped, sample %h", sample);
      end
      if (cmd_gen != seen_gen)
      begin
        // First sample after a flush or the first play
        if (resync_exact)
        begin
          assert (sample == resync_val) else
          begin
            sample_errors++;
            $display("error sample: got %h, expected %h", sample, resync_val);
          end
        end
        seen_gen <= cmd_gen;
      end
      else
      begin
        expected_sample = next_sample(prev_sample, dir_fwd);
        assert (sample == expected_sample) else
        begin
          sample_errors++;
          $display("error sample: got %h, expected %h", sample, expected_sample);
        end
        if (dir_fwd && prev_sample == 16'(LAST_INDEX) && sample == '0)
          fwd_wraps <= fwd_wraps + 1;
        if (!dir_fwd && prev_sample == '0 && sample == 16'(LAST_INDEX))
          bwd_wraps <= bwd_wraps + 1;
      end
      prev_sample <= sample;
      sample_count <= sample_count + 1;
    end
  end

  // ==============================
  // Stimulus tasks
  // ==============================
  task automatic send_cmd(input logic [7:0] code);
    kbd_ascii = code;
    kbd_valid = 1'b1;
    @(negedge CLK_50M);
    kbd_valid = 1'b0;
    @(negedge CLK_50M);
  endtask

  task automatic mark_discontinuity(input bit exact, input int value);
    resync_exact <= exact;
    resync_val <= value[SW-1:0];
    cmd_gen <= cmd_gen + 1;
  endtask

  task automatic wait_samples(input int n);
    int target;
    target = sample_count + n;
    while (sample_count < target)
      @(negedge CLK_50M);
  endtask

  task automatic check_divisor();
    assert (divisor == exp_div) else
    begin
      divisor_errors++;
      $display("error divisor: got %h, expected %h", divisor, exp_div);
    end
  endtask

  task automatic hold_speed_key(input bit faster, input int cycles);
    if (faster)
      speed_up = 1'b1;
    else
      speed_down = 1'b1;
    repeat (cycles) @(negedge CLK_50M);
    speed_up = 1'b0;
    speed_down = 1'b0;
    @(negedge CLK_50M);
    exp_div = stepped_divisor(exp_div, steps_for_hold(cycles), faster);
    check_divisor();
  endtask

  task automatic press_speed_reset();
    speed_reset = 1'b1;
    @(negedge CLK_50M);
    speed_reset = 1'b0;
    @(negedge CLK_50M);
    exp_div = ipod_control_pkg::DIVISOR_DEFAULT;
    check_divisor();
  endtask

  task automatic report_counts();
    $display("errors: sample %0d, divisor %0d, quiet %0d, wrap %0d",
             sample_errors, divisor_errors, quiet_errors, wrap_errors);
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial
  begin
    kbd_ascii = 8'h00;
    kbd_valid = 1'b0;
    speed_up = 1'b0;
    speed_down = 1'b0;
    speed_reset = 1'b0;
    reset = 1'b1;
    repeat (16) @(negedge CLK_50M);
    reset = 1'b0;
    @(negedge CLK_50M);

    // Speed keys while still stopped
    exp_div = ipod_control_pkg::DIVISOR_DEFAULT;
    check_divisor();
    hold_speed_key(1'b1, 1);
    press_speed_reset();
    hold_speed_key(1'b0, 2 * REPEAT_CYCLES + 1);
    press_speed_reset();
    hold_speed_key(1'b0, 40 * REPEAT_CYCLES + 1);
    press_speed_reset();
    hold_speed_key(1'b1, 20 * REPEAT_CYCLES + 1);

    // Play from word 0 forward
    quiet <= 1'b0;
    mark_discontinuity(1'b1, 0);
    send_cmd(ipod_control_pkg::CMD_PLAY);
    wait_samples(FWD_SAMPLES);

    send_cmd(ipod_control_pkg::CMD_BACKWARD);
    dir_fwd <= 1'b0;
    mark_discontinuity(1'b0, 0);
    wait_samples(BWD_SAMPLES);

    send_cmd(ipod_control_pkg::CMD_RESTART);
    mark_discontinuity(1'b1, LAST_INDEX);
    wait_samples(SHORT_SAMPLES);

    // Pause then resume where it stopped
    send_cmd(ipod_control_pkg::CMD_PAUSE);
    quiet <= 1'b1;
    repeat (PAUSE_TICKS * int'(divisor)) @(negedge CLK_50M);
    quiet <= 1'b0;
    send_cmd(ipod_control_pkg::CMD_PLAY);
    wait_samples(SHORT_SAMPLES);

    send_cmd(ipod_control_pkg::CMD_FORWARD);
    dir_fwd <= 1'b1;
    mark_discontinuity(1'b0, 0);
    wait_samples(SHORT_SAMPLES);

    send_cmd(ipod_control_pkg::CMD_RESTART);
    mark_discontinuity(1'b1, 0);
    wait_samples(SHORT_SAMPLES);

    assert (fwd_wraps > 0 && bwd_wraps > 0) else
    begin
      wrap_errors++;
      $display("playback did not wrap at the song ends in both directions");
    end

    report_counts();
    if (sample_errors + divisor_errors + quiet_errors + wrap_errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // Watchdog sized for every tick at the slowest rate
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK_50M);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    report_counts();
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
hw/ipod_audio_pkg.sv
hw/ipod_control_pkg.sv
hw/player_control.sv
hw/sample_tick_gen.sv
hw/flash_reader.sv
hw/sample_fifo.sv
hw/sample_player.sv
hw/ipod_top.sv
test/ipod_properties.sv
test/ipod_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module ipod_tb -f all.f -o ipod_sim &&
./obj_dir/ipod_sim | tee /dev/stderr | grep -qx "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
